/* filelist.f */
verilog/icachePkg.sv
verilog/icacheFetchDecode.sv
verilog/icacheTagWays.sv
verilog/icacheLineMem.sv
verilog/icacheWordSelect.sv
verilog/icacheTop.sv
testbench/icacheTb_checker.sv
testbench/icacheScoreboard.sv
testbench/icacheTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = icacheTb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/icache_stim.txt */
# op addr lineData(word3..word0) fault, then for fetches: expHit expWord expFault
# op is 0 fetch, 1 fill, 2 invalidate line, 3 invalidate all; all values in hex
0 00001000 00000000000000000000000000000000 0 0 00000000 0
1 00001000 0a0000030a0000020a0000010a000000 1 0 00000000 0
0 00001000 00000000000000000000000000000000 0 1 0a000000 1
0 00001004 00000000000000000000000000000000 0 1 0a000001 1
0 00001008 00000000000000000000000000000000 0 1 0a000002 1
0 0000100c 00000000000000000000000000000000 0 1 0a000003 1
1 00002010 20000003200000022000000120000000 0 0 00000000 0
1 00002110 21000003210000022100000121000000 2 0 00000000 0
1 00002210 22000003220000022200000122000000 3 0 00000000 0
1 00002310 23000003230000022300000123000000 0 0 00000000 0
0 00002010 00000000000000000000000000000000 0 1 20000000 0
0 00002114 00000000000000000000000000000000 0 1 21000001 2
0 00002218 00000000000000000000000000000000 0 1 22000002 3
0 0000231c 00000000000000000000000000000000 0 1 23000003 0
1 00002110 51000003510000025100000151000000 1 0 00000000 0
0 00002118 00000000000000000000000000000000 0 1 51000002 1
2 00002110 00000000000000000000000000000000 0 0 00000000 0
0 00002114 00000000000000000000000000000000 0 0 00000000 0
0 00002010 00000000000000000000000000000000 0 1 20000000 0
0 00002218 00000000000000000000000000000000 0 1 22000002 3
0 0000231c 00000000000000000000000000000000 0 1 23000003 0
3 00000000 00000000000000000000000000000000 0 0 00000000 0
0 00001004 00000000000000000000000000000000 0 0 00000000 0
0 00002010 00000000000000000000000000000000 0 0 00000000 0

/* testbench/icacheTb.sv */
// ----------------------------------------------------------------------
// Instruction cache testbench: commands and expected fetch results come
// from testbench/icache_stim.txt, read relative to the project root
// rspReady stalls at random; at most 64 stimulus lines are used
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheTb;
	import icachePkg::*;

	localparam int maxLines = 64;

	logic        clk;
	logic        rst;
	logic        cmdValid;
	logic        cmdReady;
	cacheCmd_t   cmd;
	cacheRsp_t   expRsp;
	logic        rspValid;
	logic        rspReady;
	cacheRsp_t   rsp;
	cacheCmd_t   stimCmd [maxLines];
	cacheRsp_t   stimExp [maxLines];
	int          numLines;
	int          numFetches;
	int          timeoutLimit;
	int          tbErrors;
	int          sbErrors;
	int          sbChecked;
	int          cycles;
	logic        stimLoaded = 1'b0;
	logic [31:0] rngState = 32'h2f68_e0b8;

	icacheTop icacheTop_i (
		.clk      (clk),
		.rst      (rst),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.cmd      (cmd),
		.rspValid (rspValid),
		.rspReady (rspReady),
		.rsp      (rsp)
	);

	icacheScoreboard scoreboard_i (
		.clk      (clk),
		.rst      (rst),
		.cmdValid (cmdValid),
		.cmdReady (cmdReady),
		.cmd      (cmd),
		.expRsp   (expRsp),
		.rspValid (rspValid),
		.rspReady (rspReady),
		.rsp      (rsp),
		.errors   (sbErrors),
		.checked  (sbChecked)
	);

	bind icacheTop icacheTb_checker handshakeChecker_i (
		.clk(clk), .rst(rst), .cmdReady(cmdReady),
		.rspValid(rspValid), .rspReady(rspReady), .rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Roughly one cycle in four holds the response back
	// During reset the result stage is empty, so stalls there have no effect
	always @(posedge clk) begin
		#1;
		rngState = nextRandom(rngState);
		rspReady = (rngState[1:0] != 2'b00);
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	// Lines that do not hold all seven columns, such as comments, are skipped
	task automatic loadStimulus();
		int                    fd;
		int                    got;
		string                 line;
		logic [1:0]            opRaw;
		logic [addrWidth-1:0]  addr;
		logic [lineWidth-1:0]  data;
		logic [faultWidth-1:0] fault;
		logic                  hit;
		logic [wordWidth-1:0]  word;
		logic [faultWidth-1:0] expFault;
		numLines   = 0;
		numFetches = 0;
		fd = $fopen("testbench/icache_stim.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && numLines < maxLines) begin
				got = $fgets(line, fd);
				if (got > 0)
					got = $sscanf(line, "%h %h %h %h %h %h %h",
						opRaw, addr, data, fault, hit, word, expFault);
				if (got == 7) begin
					stimCmd[numLines] = '{op: cacheOp_e'(opRaw), addr: addr,
						lineData: data, fault: fault};
					stimExp[numLines] = '{hit: hit, word: word, fault: expFault};
					if (cacheOp_e'(opRaw) == opFetch)
						numFetches++;
					numLines++;
				end
			end
			$fclose(fd);
		end
	endtask

	// Called just after a rising edge; returns just after the transfer edge
	task automatic sendCommand(input cacheCmd_t c, input cacheRsp_t e);
		cmdValid = 1'b1;
		cmd      = c;
		expRsp   = e;
		@(negedge clk);
		while (!cmdReady)
			@(negedge clk);
		@(posedge clk);
		#1;
		cmdValid = 1'b0;
	endtask

	initial begin
		rst      = 1'b1;
		cmdValid = 1'b0;
		cmd      = '0;
		expRsp   = '0;
		rspReady = 1'b1;
		tbErrors = 0;
		loadStimulus();
		timeoutLimit = numLines * 20 + 100;
		stimLoaded   = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < numLines; i++)
			sendCommand(stimCmd[i], stimExp[i]);
		while (sbChecked < numFetches)
			@(posedge clk);
		// A few idle cycles so that a duplicated response would show up
		repeat (10) @(posedge clk);
		if (numLines == 0) begin
			$display("Error: no stimulus lines could be read from the stimulus file");
			tbErrors++;
		end
		$display("Summary: %0d of %0d fetches checked, %0d errors",
			sbChecked, numFetches, sbErrors + tbErrors);
		if (sbErrors == 0 && tbErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog, armed once the stimulus length is known
	initial begin
		cycles = 0;
		wait (stimLoaded);
		while (cycles < timeoutLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles, %0d of %0d fetches answered",
			timeoutLimit, sbChecked, numFetches);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/icacheScoreboard.sv */
// ----------------------------------------------------------------------
// Scoreboard: queues the expected result of each accepted fetch and
// compares it with the responses in order
// Word and fault are only compared when a hit is expected
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheScoreboard (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmdValid,
	input  logic                 cmdReady,
	input  icachePkg::cacheCmd_t cmd,
	input  icachePkg::cacheRsp_t expRsp,
	input  logic                 rspValid,
	input  logic                 rspReady,
	input  icachePkg::cacheRsp_t rsp,
	output int                   errors,
	output int                   checked
);
	import icachePkg::*;

	typedef struct packed {
		logic [addrWidth-1:0] addr;
		cacheRsp_t            exp;
	} pending_t;

	// Fetches that were accepted but not yet answered, oldest first
	pending_t pending [$];

	always @(posedge clk) begin
		pending_t entry;
		int       bad;
		bad = 0;
		if (rst) begin
			errors  <= 0;
			checked <= 0;
			pending.delete();
		end else begin
			// ----------------------------------------------------------
			// Response side
			// ----------------------------------------------------------
			if (rspValid && rspReady) begin
				if (pending.size() == 0) begin
					$display("Error at %0t: response arrived with no fetch outstanding", $time);
					errors <= errors + 1;
				end else begin
					entry = pending.pop_front();
					if (rsp.hit !== entry.exp.hit) begin
						$display("Mismatch at %0t: rsp.hit expected %0b actual %0b",
							$time, entry.exp.hit, rsp.hit);
						bad++;
					end
					if (entry.exp.hit && rsp.word !== entry.exp.word) begin
						$display("Mismatch at %0t: rsp.word expected %h actual %h",
							$time, entry.exp.word, rsp.word);
						bad++;
					end
					if (entry.exp.hit && rsp.fault !== entry.exp.fault) begin
						$display("Mismatch at %0t: rsp.fault expected %0d actual %0d",
							$time, entry.exp.fault, rsp.fault);
						bad++;
					end
					$display("Test %0d: fetch %h hit %0b word %h fault %0d %s", checked + 1,
						entry.addr, rsp.hit, rsp.word, rsp.fault, (bad == 0) ? "ok" : "FAILED");
					errors  <= errors + bad;
					checked <= checked + 1;
				end
			end
			// Pushed after the pop, since a fetch needs two edges to answer
			if (cmdValid && cmdReady && cmd.op == opFetch)
				pending.push_back('{addr: cmd.addr, exp: expRsp});
		end
	end

endmodule

`default_nettype wire

/* testbench/icacheTb_checker.sv */
// ----------------------------------------------------------------------
// Handshake assertions, bound into icacheTop
// Assumes rst is high from time zero until the first release
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheTb_checker (
	input logic                 clk,
	input logic                 rst,
	input logic                 cmdReady,
	input logic                 rspValid,
	input logic                 rspReady,
	input icachePkg::cacheRsp_t rsp
);

	// A stalled response must stay offered and unchanged
	rspHeld: assert property (@(posedge clk) disable iff (rst)
		rspValid && !rspReady |=> rspValid && $stable(rsp))
		else $error("Response changed or dropped while rspReady was low");

	// The first edge after reset release still sees an empty result stage
	quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !rspValid)
		else $error("rspValid was high in the cycle after reset");

	readyKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(cmdReady))
		else $error("cmdReady was unknown");

endmodule

`default_nettype wire

/* verilog/icacheTop.sv */
// ----------------------------------------------------------------------
// Instruction cache top: decode, execute and result stages plus data
// Three commands in flight at most; fetch latency is two edges unstalled
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheTop (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmdValid,
	output logic                 cmdReady,
	input  icachePkg::cacheCmd_t cmd,
	output logic                 rspValid,
	input  logic                 rspReady,
	output icachePkg::cacheRsp_t rsp
);
	import icachePkg::*;

	logic                               advance;
	logic                               decValid;
	decodedCmd_t                        dec;
	logic                               exValid;
	execResult_t                        ex;
	logic                               memWrite;
	logic [wayBits+indexBits-1:0]       memLine;
	logic [lineWidth+faultWidth-1:0]    memData;

	// Commands are taken exactly when the pipeline moves
	assign cmdReady = advance;

	// ------------------------------------------------------------------
	// Stages
	// ------------------------------------------------------------------
	icacheFetchDecode decode_i (
		.clk      (clk),
		.rst      (rst),
		.cmdValid (cmdValid),
		.cmd      (cmd),
		.advance  (advance),
		.decValid (decValid),
		.dec      (dec)
	);

	icacheTagWays execute_i (
		.clk      (clk),
		.rst      (rst),
		.decValid (decValid),
		.dec      (dec),
		.advance  (advance),
		.exValid  (exValid),
		.ex       (ex),
		.memWrite (memWrite),
		.memLine  (memLine),
		.memData  (memData)
	);

	// Fill payload goes straight from the decode register into the array
	icacheLineMem lineMem_i (
		.clk      (clk),
		.wr       (memWrite),
		.lineAddr (memLine),
		.wrData   ({dec.fault, dec.lineData}),
		.rdData   (memData)
	);

	icacheWordSelect result_i (
		.clk      (clk),
		.rst      (rst),
		.exValid  (exValid),
		.ex       (ex),
		.rspReady (rspReady),
		.advance  (advance),
		.rspValid (rspValid),
		.rsp      (rsp)
	);

endmodule

`default_nettype wire

/* verilog/icacheWordSelect.sv */
// ----------------------------------------------------------------------
// Result stage: word select and response register
// Produces the single advance signal for the whole pipeline
// Only fetches respond; on a miss word and fault read as zero
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheWordSelect (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   exValid,
	input  icachePkg::execResult_t ex,
	input  logic                   rspReady,
	output logic                   advance,
	output logic                   rspValid,
	output icachePkg::cacheRsp_t   rsp
);
	import icachePkg::*;

	logic [wordWidth-1:0] selWord;
	logic                 makeRsp;

	// Pipeline moves when the response slot is empty or being drained
	assign advance = !rspValid || rspReady;

	// Word offset picks one 32-bit slice of the line
	assign selWord = ex.lineData[ex.wordSel*wordWidth +: wordWidth];
	assign makeRsp = exValid && ex.isFetch;

	always_ff @(posedge clk) begin
		if (rst) begin
			rspValid <= 1'b0;
		end else if (advance) begin
			rspValid <= makeRsp;
		end
	end

	// Payload only loads for a new fetch, so it stays put while stalled
	always_ff @(posedge clk) begin
		if (advance && makeRsp) begin
			rsp.hit   <= ex.hit;
			rsp.word  <= ex.hit ? selWord : '0;
			rsp.fault <= ex.hit ? ex.fault : '0;
		end
	end

endmodule

`default_nettype wire

/* verilog/icacheLineMem.sv */
// ----------------------------------------------------------------------
// Line data plus fault storage, one entry per way and set
// Combinational read, write on the clock edge; contents start unknown
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheLineMem (
	input  logic clk,
	input  logic wr,
	input  logic [icachePkg::wayBits+icachePkg::indexBits-1:0]   lineAddr,
	input  logic [icachePkg::lineWidth+icachePkg::faultWidth-1:0] wrData,
	output logic [icachePkg::lineWidth+icachePkg::faultWidth-1:0] rdData
);
	import icachePkg::*;

	// Entry layout is {fault, line}, addressed by {way, set}
	logic [lineWidth+faultWidth-1:0] mem [numWays*numSets];

	always_ff @(posedge clk) begin
		if (wr)
			mem[lineAddr] <= wrData;
	end

	// A read in the same cycle as a write still returns the old entry
	assign rdData = mem[lineAddr];

endmodule

`default_nettype wire

/* verilog/icacheTagWays.sv */
// ----------------------------------------------------------------------
// Execute stage: four-way tag compare, replacement choice, invalidates
// Arrays are read combinationally and written on the advancing edge
// Fill way: present tag first, then lowest invalid way, then the LFSR
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheTagWays (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   decValid,
	input  icachePkg::decodedCmd_t dec,
	input  logic                   advance,
	output logic                   exValid,
	output icachePkg::execResult_t ex,
	output logic                   memWrite,
	output logic [icachePkg::wayBits+icachePkg::indexBits-1:0] memLine,
	input  logic [icachePkg::lineWidth+icachePkg::faultWidth-1:0] memData
);
	import icachePkg::*;

	// Tag and valid storage, one entry per way and set
	logic [tagBits-1:0] tagMem [numWays][numSets];
	logic [numSets-1:0] validMem [numWays];

	logic [15:0]        lfsr;
	logic [numWays-1:0] wayHit;
	logic [numWays-1:0] wayFree;
	logic [wayBits-1:0] hitWay;
	logic [wayBits-1:0] freeWay;
	logic [wayBits-1:0] fillWay;
	logic [wayBits-1:0] lineWay;
	logic               anyHit;
	logic               anyFree;
	logic               stepFill;

	// ------------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------------
	// Scanning downwards leaves the lowest matching way in each encoder
	always_comb begin
		hitWay  = '0;
		freeWay = '0;
		for (int w = numWays - 1; w >= 0; w--) begin
			wayHit[w]  = validMem[w][dec.index] && (tagMem[w][dec.index] == dec.tag);
			wayFree[w] = !validMem[w][dec.index];
			if (wayHit[w])
				hitWay = wayBits'(w);
			if (wayFree[w])
				freeWay = wayBits'(w);
		end
	end

	assign anyHit  = |wayHit;
	assign anyFree = |wayFree;

	// Refill of a present tag reuses its way so no duplicate tag appears
	assign fillWay = anyHit ? hitWay : (anyFree ? freeWay : lfsr[wayBits-1:0]);

	// Fetches read the hit way; on a miss the data is ignored downstream
	assign lineWay  = (dec.op == opFill) ? fillWay : hitWay;
	assign memLine  = {lineWay, dec.index};
	assign stepFill = advance && decValid && (dec.op == opFill);
	assign memWrite = stepFill;

	// ------------------------------------------------------------------
	// Valid bits and replacement LFSR
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < numWays; w++)
				validMem[w] <= '0;
			lfsr <= lfsrSeed;
		end else if (advance && decValid) begin
			case (dec.op)
				opFill: begin
					validMem[fillWay][dec.index] <= 1'b1;
					// Taps 16,14,13,11 give a maximal length sequence
					lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
				end
				opInvLine: begin
					for (int w = 0; w < numWays; w++)
						if (wayHit[w])
							validMem[w][dec.index] <= 1'b0;
				end
				opInvAll: begin
					for (int w = 0; w < numWays; w++)
						validMem[w] <= '0;
				end
				default: ;
			endcase
		end
	end

	// Tags need no clearing since a stale tag is masked by its valid bit
	always_ff @(posedge clk) begin
		if (stepFill)
			tagMem[fillWay][dec.index] <= dec.tag;
	end

	// Stage register towards the result stage
	always_ff @(posedge clk) begin
		if (rst) begin
			exValid <= 1'b0;
		end else if (advance) begin
			exValid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex.isFetch  <= (dec.op == opFetch);
			ex.hit      <= anyHit;
			ex.wordSel  <= dec.wordSel;
			ex.lineData <= memData[lineWidth-1:0];
			ex.fault    <= memData[lineWidth +: faultWidth];
		end
	end

endmodule

`default_nettype wire

/* verilog/icacheFetchDecode.sv */
// ----------------------------------------------------------------------
// Decode stage: takes a command when advance is high
// The sender must hold cmd stable until it is accepted
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icacheFetchDecode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmdValid,
	input  icachePkg::cacheCmd_t   cmd,
	input  logic                   advance,
	output logic                   decValid,
	output icachePkg::decodedCmd_t dec
);
	import icachePkg::*;

	// Stage valid bit
	// A bubble enters whenever nothing is offered on an advancing edge
	always_ff @(posedge clk) begin
		if (rst) begin
			decValid <= 1'b0;
		end else if (advance) begin
			decValid <= cmdValid;
		end
	end

	// ------------------------------------------------------------------
	// Address split
	// ------------------------------------------------------------------
	// Tag sits above the index, the index above the word offset, and the
	// two byte bits at the bottom are dropped
	always_ff @(posedge clk) begin
		if (advance && cmdValid) begin
			dec.op       <= cmd.op;
			dec.tag      <= cmd.addr[addrWidth-1 -: tagBits];
			dec.index    <= cmd.addr[byteBits+offsetBits +: indexBits];
			dec.wordSel  <= cmd.addr[byteBits +: offsetBits];
			// Line payload only matters for fills but rides along anyway
			dec.lineData <= cmd.lineData;
			dec.fault    <= cmd.fault;
		end
	end

endmodule

`default_nettype wire

/* verilog/icachePkg.sv */
// ----------------------------------------------------------------------
// Geometry, opcodes and stage structs shared by the instruction cache
// Byte addresses only; one 32-bit word is returned per fetch
// Fault bits arrive with a fill and are stored with the line
// ----------------------------------------------------------------------
`default_nettype none

package icachePkg;

	// Cache geometry
	localparam int addrWidth    = 32;
	localparam int wordWidth    = 32;
	localparam int wordsPerLine = 4;
	localparam int numWays      = 4;
	localparam int numSets      = 16;
	localparam int faultWidth   = 2;

	// Address fields, derived from the geometry above
	localparam int byteBits   = $clog2(wordWidth / 8);
	localparam int offsetBits = $clog2(wordsPerLine);
	localparam int indexBits  = $clog2(numSets);
	localparam int tagBits    = addrWidth - indexBits - offsetBits - byteBits;
	localparam int wayBits    = $clog2(numWays);
	localparam int lineWidth  = wordWidth * wordsPerLine;

	// Replacement LFSR start value, must never be zero
	localparam logic [15:0] lfsrSeed = 16'hACE1;

	typedef enum logic [1:0] {
		opFetch   = 2'd0,
		opFill    = 2'd1,
		opInvLine = 2'd2,
		opInvAll  = 2'd3
	} cacheOp_e;

	// Command as it arrives from outside
	typedef struct packed {
		cacheOp_e                op;
		logic [addrWidth-1:0]    addr;
		logic [lineWidth-1:0]    lineData;
		logic [faultWidth-1:0]   fault;
	} cacheCmd_t;

	// Decode to execute
	typedef struct packed {
		cacheOp_e                op;
		logic [tagBits-1:0]      tag;
		logic [indexBits-1:0]    index;
		logic [offsetBits-1:0]   wordSel;
		logic [lineWidth-1:0]    lineData;
		logic [faultWidth-1:0]   fault;
	} decodedCmd_t;

	// Execute to result, lineData is the line read from the hit way
	typedef struct packed {
		logic                    isFetch;
		logic                    hit;
		logic [offsetBits-1:0]   wordSel;
		logic [lineWidth-1:0]    lineData;
		logic [faultWidth-1:0]   fault;
	} execResult_t;

	typedef struct packed {
		logic                    hit;
		logic [wordWidth-1:0]    word;
		logic [faultWidth-1:0]   fault;
	} cacheRsp_t;

endpackage

`default_nettype wire
